//--- verilog/mem_pkg.sv
package mem_pkg;

    localparam int xlen = 64;

    // operation kind handed over from the previous stage
    typedef enum logic [2:0] {
        op_none  = 3'd0,
        op_load  = 3'd1,
        op_store = 3'd2,
        op_csrrw = 3'd3,
        op_csrrs = 3'd4,
        op_ecall = 3'd5,
        op_mret  = 3'd6
    } mem_op_e;

    // load size and signedness
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_ld  = 3'b011;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_lwu = 3'b110;

    // machine CSR addresses
    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mie     = 12'h304;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;

    // CLINT registers
    localparam logic [xlen-1:0] clint_mtimecmp_addr = 64'h0000_0000_0200_4000;
    localparam logic [xlen-1:0] clint_mtime_addr    = 64'h0000_0000_0200_BFF8;

    localparam logic [xlen-1:0] mcause_ecall = 64'd11;
    localparam logic [xlen-1:0] mcause_mti   = 64'h8000_0000_0000_0007;

    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mie_mtie_bit     = 7;

    // load unit states
    localparam logic [2:0] ls_idle   = 3'd0;
    localparam logic [2:0] ls_req    = 3'd1;
    localparam logic [2:0] ls_wait   = 3'd2;
    localparam logic [2:0] ls_mmio   = 3'd3;
    localparam logic [2:0] ls_finish = 3'd4;

    // one read dword seen as a whole or as lanes
    typedef union packed {
        logic [63:0]       dword;
        logic [1:0][31:0]  words;
        logic [3:0][15:0]  halves;
        logic [7:0][7:0]   bytes;
    } dword_u;

endpackage

//--- verilog/stage_ifs.sv
`timescale 1ns/1ns

// completed load or CLINT access
interface load_rsp_if import mem_pkg::*; ();
    logic       valid;
    dword_u     rdata;
    logic [2:0] funct3;
    logic [2:0] byte_off;
    logic       is_load;

    modport src (output valid, output rdata, output funct3, output byte_off, output is_load);
    modport dst (input valid, input rdata, input funct3, input byte_off, input is_load);
endinterface

// CSR or pass-through result, or a redirect
interface csr_rsp_if import mem_pkg::*; ();
    logic            valid;
    logic [xlen-1:0] rdata;
    logic            trap_valid;
    logic [xlen-1:0] trap_pc;

    modport src (output valid, output rdata, output trap_valid, output trap_pc);
    modport dst (input valid, input rdata, input trap_valid, input trap_pc);
endinterface

//--- verilog/clint_timer.sv
`timescale 1ns/1ns

module clint_timer import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mmio_valid,
    input  logic            mmio_write,
    input  logic            mmio_sel_mtime,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rdata,
    output logic            timer_pending
);

    logic [xlen-1:0] mtime;
    logic [xlen-1:0] mtimecmp;

    // free running, one tick per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    // all ones keeps the interrupt quiet until software programs it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (mmio_valid && mmio_write && !mmio_sel_mtime) begin
            mtimecmp <= wdata;
        end
    end

    // read data is captured on the access cycle
    always_ff @(posedge clk) begin
        if (mmio_valid) begin
            if (mmio_sel_mtime) begin
                rdata <= mtime;
            end else begin
                rdata <= mtimecmp;
            end
        end
    end

    assign timer_pending = (mtime >= mtimecmp);

    // mtime is read only here
    a_no_mtime_write: assert property (@(posedge clk) disable iff (!rst_n)
        mmio_valid && mmio_write |-> !mmio_sel_mtime);

endmodule

//--- verilog/load_unit.sv
`timescale 1ns/1ns

module load_unit import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  mem_op_e         op,
    input  logic [2:0]      funct3,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic            busy,
    output logic            bus_req,
    output logic [xlen-1:0] bus_addr,
    input  logic            bus_rvalid,
    input  logic [xlen-1:0] bus_rdata,
    output logic            timer_pending,
    load_rsp_if.src         rsp
);

    logic [2:0]      state;
    logic [2:0]      state_nxt;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] addr_q;
    logic [2:0]      funct3_q;
    logic            is_load_q;
    logic            is_mem_op;
    logic            hit_clint;
    logic            start;
    logic            mmio_valid;
    logic [xlen-1:0] clint_rdata;

    assign is_mem_op = (op == op_load) || (op == op_store);

    // a store brings its data in src2, its offset is already folded into src1
    assign addr = (op == op_store) ? src1 : src1 + src2;

    assign hit_clint = (addr == clint_mtimecmp_addr) || (addr == clint_mtime_addr);
    assign start     = in_valid && is_mem_op && (state == ls_idle);

    // CLINT is accessed on the strobe cycle itself
    assign mmio_valid = start && hit_clint;

    clint_timer clint_timer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .mmio_valid     (mmio_valid),
        .mmio_write     (op == op_store),
        .mmio_sel_mtime (addr == clint_mtime_addr),
        .wdata          (src2),
        .rdata          (clint_rdata),
        .timer_pending  (timer_pending)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            ls_idle: begin
                if (start && hit_clint) begin
                    state_nxt = ls_mmio;
                end else if (start && op == op_load) begin
                    state_nxt = ls_req;
                end
                // stores to main memory are not handled and simply drop
            end
            ls_req:    state_nxt = ls_wait;
            ls_wait: begin
                if (bus_rvalid) begin
                    state_nxt = ls_finish;
                end
            end
            ls_mmio:   state_nxt = ls_finish;
            ls_finish: state_nxt = ls_idle;
            default:   state_nxt = ls_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ls_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q    <= addr;
            funct3_q  <= funct3;
            is_load_q <= (op == op_load);
        end
    end

    // finish is the writeback cycle, still busy
    assign busy     = (state != ls_idle);
    assign bus_req  = (state == ls_req);
    assign bus_addr = {addr_q[xlen-1:3], 3'b000};

    // response goes out as the access completes
    assign rsp.valid    = (state == ls_mmio) || (state == ls_wait && bus_rvalid);
    assign rsp.rdata    = (state == ls_mmio) ? clint_rdata : bus_rdata;
    assign rsp.funct3   = funct3_q;
    assign rsp.byte_off = addr_q[2:0];
    assign rsp.is_load  = is_load_q;

    a_rvalid_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rvalid |-> state == ls_wait);

    a_no_op_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && is_mem_op |-> !busy);

endmodule

//--- verilog/csr_trap.sv
`timescale 1ns/1ns

module csr_trap import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  mem_op_e         op,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] src1,
    input  logic [11:0]     csr_addr,
    input  logic [xlen-1:0] alu_res,
    input  logic            timer_pending,
    output logic            timer_irq,
    csr_rsp_if.src          rsp
);

    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mie;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] csr_wdata;
    logic            take_irq;
    logic            op_ok;
    logic            do_csr;
    logic            do_ecall;
    logic            do_mret;

    assign timer_irq = timer_pending && mstatus[mstatus_mie_bit] && mie[mie_mtie_bit];

    // interrupt wins over whatever was strobed
    assign take_irq = in_valid && timer_irq;
    assign op_ok    = in_valid && !take_irq;
    assign do_csr   = op_ok && (op == op_csrrw || op == op_csrrs);
    assign do_ecall = op_ok && (op == op_ecall);
    assign do_mret  = op_ok && (op == op_mret);

    // unknown addresses read as zero
    always_comb begin
        case (csr_addr)
            csr_mstatus: csr_rdata = mstatus;
            csr_mie:     csr_rdata = mie;
            csr_mtvec:   csr_rdata = mtvec;
            csr_mepc:    csr_rdata = mepc;
            csr_mcause:  csr_rdata = mcause;
            default:     csr_rdata = '0;
        endcase
    end

    assign csr_wdata = (op == op_csrrs) ? (csr_rdata | src1) : src1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= '0;
            mie     <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (take_irq || do_ecall) begin
            mepc   <= pc;
            mcause <= take_irq ? mcause_mti : mcause_ecall;
            mstatus[mstatus_mpie_bit] <= mstatus[mstatus_mie_bit];
            mstatus[mstatus_mie_bit]  <= 1'b0;
        end else if (do_mret) begin
            mstatus[mstatus_mie_bit]  <= mstatus[mstatus_mpie_bit];
            mstatus[mstatus_mpie_bit] <= 1'b1;
        end else if (do_csr) begin
            case (csr_addr)
                csr_mstatus: mstatus <= csr_wdata;
                csr_mie:     mie     <= csr_wdata;
                csr_mtvec:   mtvec   <= csr_wdata;
                csr_mepc:    mepc    <= csr_wdata;
                csr_mcause:  mcause  <= csr_wdata;
                default: ;
            endcase
        end
    end

    // results leave in the strobe cycle and get registered downstream
    assign rsp.valid      = do_csr || (op_ok && op == op_none);
    assign rsp.rdata      = (op == op_none) ? alu_res : csr_rdata;
    assign rsp.trap_valid = take_irq || do_ecall || do_mret;
    assign rsp.trap_pc    = do_mret ? mepc : mtvec;

    // every strobe for this side ends in exactly one result or redirect
    a_result_or_trap: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !(op inside {op_load, op_store}) |-> rsp.valid != rsp.trap_valid);

endmodule

//--- verilog/mem_result.sv
`timescale 1ns/1ns

module mem_result import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    load_rsp_if.dst         ld,
    csr_rsp_if.dst          cs,
    output logic            wb_valid,
    output logic [xlen-1:0] wb_data,
    output logic            trap_valid,
    output logic [xlen-1:0] trap_pc
);

    logic [7:0]      byte_lane;
    logic [15:0]     half_lane;
    logic [31:0]     word_lane;
    logic [xlen-1:0] ld_value;

    // lane pick, offsets are aligned to the access size
    assign byte_lane = ld.rdata.bytes[ld.byte_off];
    assign half_lane = ld.rdata.halves[ld.byte_off[2:1]];
    assign word_lane = ld.rdata.words[ld.byte_off[2]];

    always_comb begin
        case (ld.funct3)
            f3_lb:   ld_value = {{56{byte_lane[7]}}, byte_lane};
            f3_lh:   ld_value = {{48{half_lane[15]}}, half_lane};
            f3_lw:   ld_value = {{32{word_lane[31]}}, word_lane};
            f3_ld:   ld_value = ld.rdata.dword;
            f3_lbu:  ld_value = {56'd0, byte_lane};
            f3_lhu:  ld_value = {48'd0, half_lane};
            f3_lwu:  ld_value = {32'd0, word_lane};
            default: ld_value = ld.rdata.dword;
        endcase
        // CLINT store completion writes back zero
        if (!ld.is_load) begin
            ld_value = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid   <= 1'b0;
            trap_valid <= 1'b0;
        end else begin
            wb_valid   <= ld.valid || cs.valid;
            trap_valid <= cs.trap_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ld.valid) begin
            wb_data <= ld_value;
        end else if (cs.valid) begin
            wb_data <= cs.rdata;
        end
        if (cs.trap_valid) begin
            trap_pc <= cs.trap_pc;
        end
    end

    // busy in the load unit keeps the two sides apart
    a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
        !(ld.valid && (cs.valid || cs.trap_valid)));

endmodule

//--- verilog/mem_stage_top.sv
`timescale 1ns/1ns

module mem_stage_top import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  mem_op_e         op,
    input  logic [2:0]      funct3,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic [11:0]     csr_addr,
    input  logic [xlen-1:0] alu_res,
    output logic            busy,
    output logic            bus_req,
    output logic [xlen-1:0] bus_addr,
    input  logic            bus_rvalid,
    input  logic [xlen-1:0] bus_rdata,
    output logic            wb_valid,
    output logic [xlen-1:0] wb_data,
    output logic            trap_valid,
    output logic [xlen-1:0] trap_pc,
    output logic            timer_irq
);

    logic timer_pending;

    load_rsp_if ld_rsp ();
    csr_rsp_if  cs_rsp ();

    // a taken interrupt drops the strobed memory op as well
    load_unit load_unit_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid && !timer_irq),
        .op            (op),
        .funct3        (funct3),
        .src1          (src1),
        .src2          (src2),
        .busy          (busy),
        .bus_req       (bus_req),
        .bus_addr      (bus_addr),
        .bus_rvalid    (bus_rvalid),
        .bus_rdata     (bus_rdata),
        .timer_pending (timer_pending),
        .rsp           (ld_rsp)
    );

    csr_trap csr_trap_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .op            (op),
        .pc            (pc),
        .src1          (src1),
        .csr_addr      (csr_addr),
        .alu_res       (alu_res),
        .timer_pending (timer_pending),
        .timer_irq     (timer_irq),
        .rsp           (cs_rsp)
    );

    mem_result mem_result_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ld         (ld_rsp),
        .cs         (cs_rsp),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .trap_valid (trap_valid),
        .trap_pc    (trap_pc)
    );

endmodule

//--- tb/bus_mem_model.sv
`timescale 1ns/1ns

module bus_mem_model (
    input  logic        clk,
    input  logic        bus_req,
    input  logic [63:0] bus_addr,
    output logic        bus_rvalid,
    output logic [63:0] bus_rdata
);

    // each aligned dword holds its own address under this key
    localparam logic [63:0] data_key = 64'hA5A5_5A5A_C3C3_3C3C;

    logic [63:0] req_addr;
    int unsigned extra;

    initial begin
        bus_rvalid = 1'b0;
        bus_rdata  = '0;
        forever begin
            @(posedge clk);
            bus_rvalid <= 1'b0;
            if (bus_req) begin
                req_addr = bus_addr;
                // 1 to 5 cycles from request to response
                extra = $urandom % 5;
                repeat (extra) @(posedge clk);
                bus_rvalid <= 1'b1;
                bus_rdata  <= req_addr ^ data_key;
            end
        end
    end

endmodule

//--- tb/mem_stage_tb.sv
`timescale 1ns/1ns

module mem_stage_tb import mem_pkg::*; ();

    localparam logic [63:0] data_key   = 64'hA5A5_5A5A_C3C3_3C3C;
    localparam int          num_loads  = 28;
    localparam int          num_ops    = num_loads + 20;
    localparam int          max_cycles = num_ops * 8 + 200;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    mem_op_e         op;
    logic [2:0]      funct3;
    logic [63:0]     pc;
    logic [63:0]     src1;
    logic [63:0]     src2;
    logic [11:0]     csr_addr;
    logic [63:0]     alu_res;
    logic            busy;
    logic            bus_req;
    logic [63:0]     bus_addr;
    logic            bus_rvalid;
    logic [63:0]     bus_rdata;
    logic            wb_valid;
    logic [63:0]     wb_data;
    logic            trap_valid;
    logic [63:0]     trap_pc;
    logic            timer_irq;

    // bit 64 marks a redirect and the rest is wb_data or trap_pc
    logic [64:0]     exp_q[$];
    logic [64:0]     exp_head;
    int              exp_cnt;
    int              cyc;
    logic [63:0]     exp_bus_addr;
    logic            irq_armed;

    mem_stage_top mem_stage_top_i (.*);

    bus_mem_model bus_mem_model_i (
        .clk        (clk),
        .bus_req    (bus_req),
        .bus_addr   (bus_addr),
        .bus_rvalid (bus_rvalid),
        .bus_rdata  (bus_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // counts like mtime and bounds the run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        if (cyc > max_cycles) begin
            abort_run($sformatf("timeout, the run did not end within %0d cycles", max_cycles));
        end
    end

    task automatic expect_result(input logic is_trap, input logic [63:0] value);
        exp_q.push_back({is_trap, value});
        exp_head = exp_q[0];
        exp_cnt  = exp_q.size();
    endtask

    always @(posedge clk) begin
        if (rst_n && (wb_valid || trap_valid) && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            if (exp_q.size() > 0) begin
                exp_head = exp_q[0];
            end
            exp_cnt = exp_q.size();
        end
    end

    // lane of the model dword at a extended as funct3 asks
    function automatic logic [63:0] load_expect(input logic [63:0] a, input logic [2:0] f3);
        logic [63:0] lane;
        logic [63:0] mask;
        int          bits;
        lane = ({a[63:3], 3'b000} ^ data_key) >> (8 * a[2:0]);
        bits = 8 << f3[1:0];
        mask = (bits == 64) ? '1 : (64'd1 << bits) - 64'd1;
        lane = lane & mask;
        if (!f3[2] && lane[bits-1]) begin
            lane = lane | ~mask;
        end
        return lane;
    endfunction

    // starts and ends on a rising edge with the stage idle after memory ops
    task automatic issue(input mem_op_e o, input logic [2:0] f3, input logic [63:0] s1,
                         input logic [63:0] s2, input logic [11:0] ca, input logic [63:0] p,
                         input logic [63:0] alu);
        in_valid <= 1'b1;
        op       <= o;
        funct3   <= f3;
        src1     <= s1;
        src2     <= s2;
        csr_addr <= ca;
        pc       <= p;
        alu_res  <= alu;
        @(posedge clk);
        in_valid <= 1'b0;
        if (o == op_load || o == op_store) begin
            @(negedge clk);
            while (busy) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
    endtask

    task automatic csr_op(input mem_op_e o, input logic [11:0] ca, input logic [63:0] s1,
                          input logic [63:0] old);
        expect_result(1'b0, old);
        issue(o, 3'd0, s1, 64'h0, ca, 64'h0, 64'h0);
    endtask

    a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> exp_cnt > 0 && !exp_head[64] && wb_data == exp_head[63:0])
        else abort_run($sformatf("error at %0t ns: wb_data %h, expected %h",
                                 $time, $sampled(wb_data), $sampled(exp_head[63:0])));

    a_trap_pc: assert property (@(posedge clk) disable iff (!rst_n)
        trap_valid |-> exp_cnt > 0 && exp_head[64] && trap_pc == exp_head[63:0])
        else abort_run($sformatf("error at %0t ns: trap_pc %h, expected %h",
                                 $time, $sampled(trap_pc), $sampled(exp_head[63:0])));

    a_bus_addr: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req |-> bus_addr == exp_bus_addr)
        else abort_run($sformatf("error at %0t ns: bus_addr %h, expected %h",
                                 $time, $sampled(bus_addr), $sampled(exp_bus_addr)));

    a_irq_early: assert property (@(posedge clk) disable iff (!rst_n)
        timer_irq |-> irq_armed)
        else abort_run("timer_irq rose before the interrupt was enabled and due");

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !busy && !bus_req && !wb_valid && !trap_valid)
        else abort_run("outputs were not low coming out of reset");

    a_bus_req_once: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && op == op_load && src1[31] |=> bus_req ##1 !bus_req)
        else abort_run("bus_req did not pulse exactly once after a memory load");

    a_bus_req_cause: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req |-> $past(in_valid && op == op_load && src1[31]))
        else abort_run("bus_req rose without a memory load the cycle before");

    a_load_done: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rvalid |=> wb_valid)
        else abort_run("memory load result did not follow bus_rvalid by one cycle");

    a_clint_timing: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && op inside {op_load, op_store} && !src1[31] && !timer_irq
        |=> !bus_req && busy ##1 wb_valid && !bus_req)
        else abort_run("CLINT access did not complete two cycles after its strobe");

    a_result_timing: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !timer_irq && op inside {op_none, op_csrrw, op_csrrs} |=> wb_valid)
        else abort_run("CSR or pass-through result missing one cycle after its strobe");

    a_trap_timing: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && (timer_irq || op == op_ecall || op == op_mret) |=> trap_valid && !wb_valid)
        else abort_run("redirect missing one cycle after ecall, mret or interrupt");

    a_busy_span: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(wb_valid))
        else abort_run("busy dropped before the writeback cycle of its access");

    initial begin
        logic [63:0] a;
        logic [2:0]  f3;
        logic [31:0] r;
        void'($urandom(32'h8d78_b16a));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        op           = op_none;
        funct3       = 3'd0;
        pc           = '0;
        src1         = '0;
        src2         = '0;
        csr_addr     = '0;
        alu_res      = '0;
        exp_head     = '0;
        exp_cnt      = 0;
        exp_bus_addr = '0;
        irq_armed    = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // memory loads over every funct3 aligned to size
        for (int i = 0; i < num_loads; i++) begin
            r  = $urandom;
            f3 = 3'(i % 7);
            a  = (64'h8000_1000 + r[19:0]) & ~((64'd1 << f3[1:0]) - 64'd1);
            exp_bus_addr = a & ~64'h7;
            expect_result(1'b0, load_expect(a, f3));
            issue(op_load, f3, a - 64'h100, 64'h100, 12'h0, 64'h0, 64'h0);
        end

        r = $urandom;
        expect_result(1'b0, {r, ~r});
        issue(op_none, 3'd0, 64'h0, 64'h0, 12'h0, 64'h0, {r, ~r});

        // back to back so each returns the value left by the one before
        csr_op(op_csrrw, csr_mtvec, 64'h8000_0100, 64'h0);
        csr_op(op_csrrs, csr_mtvec, 64'h4, 64'h8000_0100);
        csr_op(op_csrrs, csr_mtvec, 64'h0, 64'h8000_0104);
        csr_op(op_csrrw, 12'h7c0, 64'hdead, 64'h0);
        csr_op(op_csrrs, 12'h7c0, 64'h0, 64'h0);
        csr_op(op_csrrw, csr_mie, 64'h0, 64'h0);

        // CLINT store, load back, then mtime as seen on the access cycle
        expect_result(1'b0, 64'h0);
        issue(op_store, f3_ld, clint_mtimecmp_addr, 64'h1234_5678_9abc_def0, 12'h0, 0, 0);
        expect_result(1'b0, 64'h1234_5678_9abc_def0);
        issue(op_load, f3_ld, clint_mtimecmp_addr, 64'h0, 12'h0, 64'h0, 64'h0);
        expect_result(1'b0, 64'(cyc + 1));
        issue(op_load, f3_ld, clint_mtime_addr, 64'h0, 12'h0, 64'h0, 64'h0);

        expect_result(1'b1, 64'h8000_0104);
        issue(op_ecall, 3'd0, 64'h0, 64'h0, 12'h0, 64'h8000_2000, 64'h0);
        csr_op(op_csrrs, csr_mepc, 64'h0, 64'h8000_2000);
        csr_op(op_csrrs, csr_mcause, 64'h0, mcause_ecall);
        expect_result(1'b1, 64'h8000_2000);
        issue(op_mret, 3'd0, 64'h0, 64'h0, 12'h0, 64'h8000_2004, 64'h0);

        // mret left MPIE set, so mstatus reads 0x80 here
        csr_op(op_csrrs, csr_mie, 64'h80, 64'h0);
        csr_op(op_csrrs, csr_mstatus, 64'h8, 64'h80);
        expect_result(1'b0, 64'h0);
        irq_armed = 1'b1;
        issue(op_store, f3_ld, clint_mtimecmp_addr, 64'd5, 12'h0, 64'h0, 64'h0);
        @(negedge clk);
        while (!timer_irq) begin
            @(negedge clk);
        end
        @(posedge clk);
        // the strobed op is dropped in favour of the interrupt
        expect_result(1'b1, 64'h8000_0104);
        issue(op_none, 3'd0, 64'h0, 64'h0, 12'h0, 64'h8000_3000, 64'h55);
        csr_op(op_csrrs, csr_mcause, 64'h0, mcause_mti);
        csr_op(op_csrrs, csr_mstatus, 64'h0, 64'h80);

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d results still missing at the end of the run",
                                exp_q.size()));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- all.f
verilog/mem_pkg.sv
verilog/stage_ifs.sv
verilog/clint_timer.sv
verilog/load_unit.sv
verilog/csr_trap.sv
verilog/mem_result.sv
verilog/mem_stage_top.sv
tb/bus_mem_model.sv
tb/mem_stage_tb.sv
